//--- sim.f
logic/isa_pkg.sv
logic/bus_pkg.sv
logic/register_file.sv
logic/decode_control.sv
logic/exec_unit.sv
logic/sequencer.sv
logic/cpu_top.sv
tests/cpu_assert.sv
tests/tb_cpu.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cpu -f sim.f -o sim_cpu

output=$(./obj_dir/sim_cpu 2>&1) || true
printf '%s\n' "$output"
grep -qx "TB PASSED" <<< "$output"

//--- tests/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
	import isa_pkg::*;
	import bus_pkg::*;

	localparam int clk_period = 8;
	localparam int prog_len = 40;
	localparam int mem_words = 256;
	localparam int model_step_limit = 1000;
	// three accesses of at most five cycles per instruction, then reset, halt check and margin
	localparam int watchdog_cycles = (prog_len + 1) * 3 * 5 + 5 + 20 + 100;

	// slot kinds of the generated program
	localparam int k_alu = 0;
	localparam int k_imm = 1;
	localparam int k_branch = 2;
	localparam int k_jump = 3;
	localparam int k_wwd = 4;
	localparam int k_rjump = 5;
	localparam int k_mem = 6;
	localparam int k_inner = 7;

	logic      clk;
	logic      rst;
	mem_req_t  mem_req;
	mem_rsp_t  mem_rsp;
	out_port_t wwd_out;
	logic      cpu_halted;

	integer            seed;
	int                latency;
	logic [word_w-1:0] mem [mem_words];
	logic [word_w-1:0] ref_mem [mem_words];
	int                kind [prog_len];
	bit                landing_ok [prog_len + 1];
	mem_req_t          exp_req [$];
	logic [word_w-1:0] exp_wwd [$];
	mem_req_t          seen_req;
	mem_req_t          want_req;
	int                exp_wwd_total = 0;
	int                wwd_seen = 0;
	int                checks = 0;
	int                value_errors = 0;
	int                other_errors = 0;

	cpu_top cpu_top_i (
		.clk     (clk),
		.rst     (rst),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp),
		.wwd_out (wwd_out),
		.halted  (cpu_halted)
	);

	bind sequencer cpu_assert cpu_assert_i (
		.clk     (clk),
		.rst     (rst),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp),
		.wwd_out (wwd_out),
		.halted  (halted)
	);

	always #(clk_period / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [word_w-1:0] got,
			input logic [word_w-1:0] want);
		checks++;
		if (got !== want) begin
			value_errors++;
			$display("FAILED %s: got %h, expected %h", name, got, want);
		end
	endtask

	// first pass decides what goes where, groups of three are LHI, ORI and the user
	task automatic place_slots();
		int idx;
		int pick;
		idx = 0;
		while (idx < prog_len) begin
			pick = $random(seed) & 15;
			if (pick < 5) kind[idx] = k_alu;
			else if (pick < 8) kind[idx] = k_imm;
			else if (pick < 10) kind[idx] = k_branch;
			else if (pick < 11) kind[idx] = k_jump;
			else if (pick < 13) kind[idx] = k_wwd;
			else if (pick < 14) kind[idx] = k_rjump;
			else kind[idx] = k_mem;
			if ((kind[idx] == k_rjump || kind[idx] == k_mem) && idx + 3 > prog_len) begin
				kind[idx] = k_alu;
			end
			landing_ok[idx] = 1'b1;
			if (kind[idx] == k_rjump || kind[idx] == k_mem) begin
				kind[idx + 1] = k_inner;
				kind[idx + 2] = k_inner;
				landing_ok[idx + 1] = 1'b0;
				landing_ok[idx + 2] = 1'b0;
				idx += 3;
			end else begin
				idx += 1;
			end
		end
		landing_ok[prog_len] = 1'b1;
	endtask

	// forward only, never into the middle of a group, HLT at the latest
	function automatic int pick_target(int from);
		int t;
		t = from + 1 + ($random(seed) & 3);
		if (t > prog_len) begin
			t = prog_len;
		end
		while (!landing_ok[t]) begin
			t++;
		end
		return t;
	endfunction

	task automatic build_program();
		int               t;
		int               pick;
		logic [1:0]       ra;
		logic [1:0]       rb;
		logic [1:0]       rc;
		logic [7:0]       imm;
		logic [op_w-1:0]  op;
		logic [func_w-1:0] fn;
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = word_w'($random(seed));
		end
		for (int idx = 0; idx < prog_len; idx++) begin
			ra = 2'($random(seed));
			rb = 2'($random(seed));
			rc = 2'($random(seed));
			imm = 8'($random(seed));
			pick = $random(seed) & 255;
			case (kind[idx])
				k_alu: mem[idx] = {rtype, ra, rb, rc, 3'b000, imm[2:0]};
				k_imm: begin
					op = (pick[1:0] == 2'd1) ? ORI : ((pick[1:0] == 2'd2) ? LHI : ADI);
					mem[idx] = {op, ra, rb, imm};
				end
				k_branch: begin
					t = pick_target(idx);
					mem[idx] = {2'b00, pick[1:0], ra, rb, 8'(t - idx - 1)};
				end
				k_jump: begin
					t = pick_target(idx);
					op = pick[0] ? JAL : JMP;
					mem[idx] = {op, 12'(t)};
				end
				k_wwd: mem[idx] = {rtype, ra, 2'b00, 2'b00, WWD};
				k_rjump: begin
					t = pick_target(idx + 2);
					fn = pick[0] ? JRL : JPR;
					mem[idx] = {LHI, 2'b00, ra, 8'h00};
					mem[idx + 1] = {ORI, ra, ra, 8'(t)};
					mem[idx + 2] = {rtype, ra, rb, rc, fn};
				end
				k_mem: begin
					// base 136 to 199 with offset -8 to 7 stays inside 128 to 255
					op = pick[6] ? SWD : LWD;
					mem[idx] = {LHI, 2'b00, ra, 8'h00};
					mem[idx + 1] = {ORI, ra, ra, 8'(136 + (pick & 63))};
					mem[idx + 2] = {op, ra, rb, {{4{imm[3]}}, imm[3:0]}};
				end
				default: ;
			endcase
		end
		mem[prog_len] = {rtype, 6'b000000, HLT};
	endtask

	task automatic expect_access(input logic write, input logic [word_w-1:0] addr,
			input logic [word_w-1:0] wdata);
		mem_req_t r;
		r.valid = 1'b1;
		r.write = write;
		r.addr = addr;
		r.wdata = wdata;
		exp_req.push_back(r);
	endtask

	// ISA interpreter over its own copy of memory
	task automatic run_reference();
		logic [word_w-1:0] regs [reg_count];
		logic [word_w-1:0] pc;
		logic [word_w-1:0] ins;
		logic [word_w-1:0] a;
		logic [word_w-1:0] b;
		logic [word_w-1:0] sext;
		logic [word_w-1:0] addr;
		logic [word_w-1:0] next;
		logic [1:0]        rs;
		logic [1:0]        rt;
		logic [1:0]        rd;
		int                steps;
		bit                done;
		for (int i = 0; i < reg_count; i++) begin
			regs[i] = '0;
		end
		pc = '0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < model_step_limit) begin
			ins = ref_mem[pc[7:0]];
			expect_access(1'b0, pc, '0);
			rs = ins[11:10];
			rt = ins[9:8];
			rd = ins[7:6];
			a = regs[rs];
			b = regs[rt];
			sext = {{8{ins[7]}}, ins[7:0]};
			next = pc + 16'd1;
			case (ins[15:12])
				ADI: regs[rt] = a + sext;
				ORI: regs[rt] = a | {8'h00, ins[7:0]};
				LHI: regs[rt] = {ins[7:0], 8'h00};
				LWD: begin
					addr = a + sext;
					expect_access(1'b0, addr, '0);
					regs[rt] = ref_mem[addr[7:0]];
				end
				SWD: begin
					addr = a + sext;
					expect_access(1'b1, addr, b);
					ref_mem[addr[7:0]] = b;
				end
				BNE: if (a != b) next = next + sext;
				BEQ: if (a == b) next = next + sext;
				BGZ: if ($signed(a) > 0) next = next + sext;
				BLZ: if ($signed(a) < 0) next = next + sext;
				JMP: next = {pc[15:12], ins[11:0]};
				JAL: begin
					regs[2] = pc + 16'd1;
					next = {pc[15:12], ins[11:0]};
				end
				rtype: begin
					case (ins[5:0])
						ADD: regs[rd] = a + b;
						SUB: regs[rd] = a - b;
						AND: regs[rd] = a & b;
						ORR: regs[rd] = a | b;
						NOT: regs[rd] = ~a;
						TCP: regs[rd] = 16'd0 - a;
						SHL: regs[rd] = a << 1;
						SHR: regs[rd] = $signed(a) >>> 1;
						JPR: next = a;
						JRL: begin
							regs[2] = pc + 16'd1;
							next = a;
						end
						WWD: exp_wwd.push_back(a);
						HLT: done = 1'b1;
						default: ;
					endcase
				end
				default: ;
			endcase
			pc = next;
			steps++;
		end
		if (!done) begin
			other_errors++;
			$display("reference model did not reach HLT within %0d steps", model_step_limit);
		end
	endtask

	// memory answers each request once after 1 to 4 cycles
	always @(negedge clk) begin
		if (!rst && mem_req.valid) begin
			seen_req = mem_req;
			latency = 1 + ($random(seed) & 3);
			if (seen_req.write) begin
				mem[seen_req.addr[7:0]] = seen_req.wdata;
			end
			repeat (latency) @(posedge clk);
			#1;
			mem_rsp.valid = 1'b1;
			mem_rsp.rdata = mem[seen_req.addr[7:0]];
			@(posedge clk);
			#1;
			mem_rsp = '0;
		end
	end

	// fetch and data addresses follow the model's trace
	always @(negedge clk) begin
		if (!rst && mem_req.valid) begin
			if (exp_req.size() == 0) begin
				other_errors++;
				$display("memory request at address %h after the expected sequence ended",
					mem_req.addr);
			end else begin
				want_req = exp_req.pop_front();
				check_value("mem_req.write", 16'(mem_req.write), 16'(want_req.write));
				check_value("mem_req.addr", mem_req.addr, want_req.addr);
				if (want_req.write) begin
					check_value("mem_req.wdata", mem_req.wdata, want_req.wdata);
				end
			end
		end
	end

	always @(negedge clk) begin
		if (!rst && wwd_out.valid) begin
			wwd_seen++;
			if (exp_wwd.size() == 0) begin
				other_errors++;
				$display("WWD pulse with value %h beyond the expected ones", wwd_out.value);
			end else begin
				check_value("wwd_out.value", wwd_out.value, exp_wwd.pop_front());
			end
		end
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("timeout: the core did not halt within %0d cycles", watchdog_cycles);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		seed = 32'h530e_341e;
		clk = 1'b0;
		rst = 1'b1;
		mem_rsp = '0;
		place_slots();
		build_program();
		ref_mem = mem;
		run_reference();
		exp_wwd_total = exp_wwd.size();

		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		// nothing fetched yet
		check_value("halted", 16'(cpu_halted), 16'd0);
		check_value("wwd_out.valid", 16'(wwd_out.valid), 16'd0);
		check_value("mem_req.valid", 16'(mem_req.valid), 16'd0);

		wait (cpu_halted === 1'b1);
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			check_value("halted", 16'(cpu_halted), 16'd1);
			check_value("mem_req.valid", 16'(mem_req.valid), 16'd0);
		end

		if (exp_req.size() != 0) begin
			other_errors++;
			$display("core halted with %0d expected memory requests never issued",
				exp_req.size());
		end
		check_value("wwd pulse count", 16'(wwd_seen), 16'(exp_wwd_total));
		for (int a = 128; a < mem_words; a++) begin
			check_value($sformatf("mem[%0d]", a), mem[a], ref_mem[a]);
		end

		$display("checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- tests/cpu_assert.sv
`timescale 1ns/1ps

module cpu_assert (
	input  logic               clk,
	input  logic               rst,
	input  bus_pkg::mem_req_t  mem_req,
	input  bus_pkg::mem_rsp_t  mem_rsp,
	input  bus_pkg::out_port_t wwd_out,
	input  logic               halted
);
	logic outstanding;

	// a request stays open until its response strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			outstanding <= 1'b0;
		end else if (mem_req.valid) begin
			outstanding <= 1'b1;
		end else if (mem_rsp.valid) begin
			outstanding <= 1'b0;
		end
	end

	one_outstanding: assert property (@(posedge clk) disable iff (rst)
		mem_req.valid |-> !outstanding)
		else $error("memory request raised while another one is still open");

	req_strobe: assert property (@(posedge clk) disable iff (rst)
		mem_req.valid |=> !mem_req.valid)
		else $error("mem_req.valid held for more than one cycle");

	wwd_strobe: assert property (@(posedge clk) disable iff (rst)
		wwd_out.valid |=> !wwd_out.valid)
		else $error("wwd_out.valid held for two cycles");

	quiet_halt: assert property (@(posedge clk) disable iff (rst)
		halted |-> !mem_req.valid)
		else $error("memory request raised while halted");

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input  logic               clk,
	input  logic               rst,
	output bus_pkg::mem_req_t  mem_req,
	input  bus_pkg::mem_rsp_t  mem_rsp,
	output bus_pkg::out_port_t wwd_out,
	output logic               halted
);
	import isa_pkg::*;

	logic [word_w-1:0]     instr;
	logic [word_w-1:0]     pc;
	logic [word_w-1:0]     alu_result;
	logic [word_w-1:0]     next_pc;
	logic [word_w-1:0]     rs_data;
	logic [word_w-1:0]     rt_data;
	logic                  reg_we;
	logic [reg_addr_w-1:0] reg_waddr;
	logic [word_w-1:0]     reg_wdata;
	ctrl_t                 ctrl;

	sequencer sequencer_i (
		.clk        (clk),
		.rst        (rst),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp),
		.instr      (instr),
		.pc         (pc),
		.ctrl       (ctrl),
		.alu_result (alu_result),
		.next_pc    (next_pc),
		.rt_data    (rt_data),
		.reg_we     (reg_we),
		.reg_waddr  (reg_waddr),
		.reg_wdata  (reg_wdata),
		.wwd_value  (rs_data),
		.wwd_out    (wwd_out),
		.halted     (halted)
	);

	decode_control decode_control_i (
		.instr (instr),
		.pc    (pc),
		.ctrl  (ctrl)
	);

	exec_unit exec_unit_i (
		.ctrl       (ctrl),
		.pc         (pc),
		.rs_data    (rs_data),
		.rt_data    (rt_data),
		.alu_result (alu_result),
		.next_pc    (next_pc)
	);

	register_file register_file_i (
		.clk    (clk),
		.rst    (rst),
		.raddr1 (ctrl.rs),
		.raddr2 (ctrl.rt),
		.rdata1 (rs_data),
		.rdata2 (rt_data),
		.we     (reg_we),
		.waddr  (reg_waddr),
		.wdata  (reg_wdata)
	);

endmodule

//--- logic/sequencer.sv
`timescale 1ns/1ps

module sequencer (
	input  logic                           clk,
	input  logic                           rst,
	output bus_pkg::mem_req_t              mem_req,
	input  bus_pkg::mem_rsp_t              mem_rsp,
	output logic [isa_pkg::word_w-1:0]     instr,
	output logic [isa_pkg::word_w-1:0]     pc,
	input  isa_pkg::ctrl_t                 ctrl,
	input  logic [isa_pkg::word_w-1:0]     alu_result,
	input  logic [isa_pkg::word_w-1:0]     next_pc,
	input  logic [isa_pkg::word_w-1:0]     rt_data,
	output logic                           reg_we,
	output logic [isa_pkg::reg_addr_w-1:0] reg_waddr,
	output logic [isa_pkg::word_w-1:0]     reg_wdata,
	input  logic [isa_pkg::word_w-1:0]     wwd_value,
	output bus_pkg::out_port_t             wwd_out,
	output logic                           halted
);
	import isa_pkg::*;
	import bus_pkg::*;

	seq_state_e        state;
	logic              req_valid;
	logic              req_write;
	logic [word_w-1:0] req_addr;
	logic [word_w-1:0] req_wdata;
	logic [word_w-1:0] pc_plus_1;
	logic              is_mem_op;
	logic              issue_fetch;
	logic              issue_data;
	logic              fetch_done;
	logic              data_done;

	assign pc_plus_1 = pc + word_w'(1);
	assign is_mem_op = ctrl.mem_read | ctrl.mem_write;

	assign issue_fetch = (state == fetch_req);
	assign issue_data = (state == execute) && is_mem_op;
	// responses outside the two wait states are dropped
	assign fetch_done = (state == fetch_wait) && mem_rsp.valid;
	assign data_done = (state == mem_wait) && mem_rsp.valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fetch_req;
			pc <= '0;
			req_valid <= 1'b0;
		end else begin
			// one-cycle strobe, raised on leaving fetch_req or a memory execute
			req_valid <= issue_fetch | issue_data;
			case (state)
				fetch_req: begin
					state <= fetch_wait;
				end
				fetch_wait: begin
					if (mem_rsp.valid) begin
						state <= execute;
					end
				end
				execute: begin
					if (ctrl.is_hlt) begin
						state <= bus_pkg::halted;
					end else if (is_mem_op) begin
						state <= mem_wait;
					end else begin
						pc <= next_pc;
						state <= fetch_req;
					end
				end
				mem_wait: begin
					if (mem_rsp.valid) begin
						pc <= next_pc;
						state <= fetch_req;
					end
				end
				// halted is terminal until reset
				default: state <= state;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue_fetch) begin
			req_write <= 1'b0;
			req_addr <= pc;
			req_wdata <= '0;
		end else if (issue_data) begin
			req_write <= ctrl.mem_write;
			req_addr <= alu_result;
			req_wdata <= rt_data;
		end
		if (fetch_done) begin
			instr <= mem_rsp.rdata;
		end
	end

	assign mem_req.valid = req_valid;
	assign mem_req.write = req_write;
	assign mem_req.addr = req_addr;
	assign mem_req.wdata = req_wdata;

	// loads write back when their data arrives, everything else in execute
	assign reg_we = ((state == execute) && ctrl.reg_write && !is_mem_op)
		|| (data_done && ctrl.mem_read);
	assign reg_waddr = ctrl.write_addr;

	always_comb begin
		case (ctrl.wb_src)
			wb_mem:  reg_wdata = mem_rsp.rdata;
			wb_pc:   reg_wdata = pc_plus_1;
			default: reg_wdata = alu_result;
		endcase
	end

	assign wwd_out.valid = (state == execute) && ctrl.is_wwd;
	assign wwd_out.value = wwd_value;

	assign halted = (state == bus_pkg::halted);

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
	input  isa_pkg::ctrl_t             ctrl,
	input  logic [isa_pkg::word_w-1:0] pc,
	input  logic [isa_pkg::word_w-1:0] rs_data,
	input  logic [isa_pkg::word_w-1:0] rt_data,
	output logic [isa_pkg::word_w-1:0] alu_result,
	output logic [isa_pkg::word_w-1:0] next_pc
);
	import isa_pkg::*;

	logic [word_w-1:0] op_b;
	logic [word_w-1:0] pc_plus_1;
	logic [word_w-1:0] branch_target;
	logic              cond;
	logic              taken;

	assign op_b = ctrl.alu_src_imm ? ctrl.imm : rt_data;

	always_comb begin
		case (ctrl.alu_op)
			alu_add:    alu_result = rs_data + op_b;
			alu_sub:    alu_result = rs_data - op_b;
			alu_and:    alu_result = rs_data & op_b;
			alu_or:     alu_result = rs_data | op_b;
			alu_not:    alu_result = ~rs_data;
			alu_tcp:    alu_result = ~rs_data + 1'b1;
			alu_shl:    alu_result = {rs_data[word_w-2:0], 1'b0};
			// arithmetic shift, sign bit kept
			alu_shr:    alu_result = {rs_data[word_w-1], rs_data[word_w-1:1]};
			alu_pass_b: alu_result = op_b;
			default:    alu_result = '0;
		endcase
	end

	// branch kind is the low bits of the branch opcode
	always_comb begin
		case (opcode_e'({{(op_w - 2){1'b0}}, ctrl.branch_kind}))
			BNE:     cond = (rs_data != rt_data);
			BEQ:     cond = (rs_data == rt_data);
			BGZ:     cond = !rs_data[word_w-1] && (rs_data != '0);
			BLZ:     cond = rs_data[word_w-1];
			default: cond = 1'b0;
		endcase
	end

	assign taken = ctrl.is_branch && cond;

	assign pc_plus_1 = pc + word_w'(1);
	assign branch_target = pc_plus_1 + ctrl.imm;

	always_comb begin
		case (ctrl.pc_sel)
			pc_branch: next_pc = taken ? branch_target : pc_plus_1;
			pc_target: next_pc = ctrl.imm;
			pc_reg:    next_pc = rs_data;
			default:   next_pc = pc_plus_1;
		endcase
	end

endmodule

//--- logic/decode_control.sv
`timescale 1ns/1ps

module decode_control (
	input  logic [isa_pkg::word_w-1:0] instr,
	input  logic [isa_pkg::word_w-1:0] pc,
	output isa_pkg::ctrl_t             ctrl
);
	import isa_pkg::*;

	logic [op_w-1:0]       op_bits;
	logic [func_w-1:0]     func_bits;
	logic [reg_addr_w-1:0] rs;
	logic [reg_addr_w-1:0] rt;
	logic [reg_addr_w-1:0] rd;
	logic [imm_w-1:0]      imm8;
	logic [target_w-1:0]   target;
	opcode_e               opcode;
	func_e                 func;
	logic [word_w-1:0]     imm_sext;
	logic [word_w-1:0]     imm_zext;
	logic [word_w-1:0]     imm_high;
	logic [word_w-1:0]     jump_addr;

	// opcode | rs | rt | rd | func, or opcode | rs | rt | imm8, or opcode | target
	assign op_bits = instr[15:12];
	assign rs = instr[11:10];
	assign rt = instr[9:8];
	assign rd = instr[7:6];
	assign func_bits = instr[5:0];
	assign imm8 = instr[7:0];
	assign target = instr[11:0];

	assign opcode = opcode_e'(op_bits);
	assign func = func_e'(func_bits);

	assign imm_sext = {{(word_w - imm_w){imm8[imm_w-1]}}, imm8};
	assign imm_zext = {{(word_w - imm_w){1'b0}}, imm8};
	assign imm_high = {imm8, {(word_w - imm_w){1'b0}}};
	// jumps stay inside the current 4K page
	assign jump_addr = {pc[word_w-1:target_w], target};

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = alu_add;
		ctrl.wb_src = wb_alu;
		ctrl.pc_sel = pc_seq;
		ctrl.rs = rs;
		ctrl.rt = rt;
		ctrl.write_addr = rt;
		ctrl.imm = imm_sext;

		case (opcode)
			ADI: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			ORI: begin
				ctrl.alu_op = alu_or;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.imm = imm_zext;
			end
			LHI: begin
				ctrl.alu_op = alu_pass_b;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.imm = imm_high;
			end
			LWD: begin
				// address is rs plus the signed offset
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_src = wb_mem;
				ctrl.mem_read = 1'b1;
			end
			SWD: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			BNE, BEQ, BGZ, BLZ: begin
				ctrl.is_branch = 1'b1;
				ctrl.branch_kind = op_bits[1:0];
				ctrl.pc_sel = pc_branch;
			end
			JMP: begin
				ctrl.pc_sel = pc_target;
				ctrl.imm = jump_addr;
			end
			JAL: begin
				ctrl.pc_sel = pc_target;
				ctrl.imm = jump_addr;
				ctrl.reg_write = 1'b1;
				ctrl.write_addr = link_reg;
				ctrl.wb_src = wb_pc;
			end
			rtype: begin
				ctrl.write_addr = rd;
				case (func)
					ADD, SUB, AND, ORR, NOT, TCP, SHL, SHR: begin
						ctrl.alu_op = alu_op_e'({1'b0, func_bits[2:0]});
						ctrl.reg_write = 1'b1;
					end
					JPR: begin
						ctrl.pc_sel = pc_reg;
					end
					JRL: begin
						ctrl.pc_sel = pc_reg;
						ctrl.reg_write = 1'b1;
						ctrl.write_addr = link_reg;
						ctrl.wb_src = wb_pc;
					end
					WWD: ctrl.is_wwd = 1'b1;
					HLT: ctrl.is_hlt = 1'b1;
					default: ;
				endcase
			end
			// unknown opcodes fall through as a no-op
			default: ;
		endcase
	end

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [isa_pkg::reg_addr_w-1:0] raddr1,
	input  logic [isa_pkg::reg_addr_w-1:0] raddr2,
	output logic [isa_pkg::word_w-1:0]     rdata1,
	output logic [isa_pkg::word_w-1:0]     rdata2,
	input  logic                           we,
	input  logic [isa_pkg::reg_addr_w-1:0] waddr,
	input  logic [isa_pkg::word_w-1:0]     wdata
);
	import isa_pkg::*;

	logic [word_w-1:0] regs [reg_count];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// reads see the old value during a write cycle
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

//--- logic/bus_pkg.sv
package bus_pkg;

	// one request per strobe, a write when write is set
	typedef struct packed {
		logic                       valid;
		logic                       write;
		logic [isa_pkg::word_w-1:0] addr;
		logic [isa_pkg::word_w-1:0] wdata;
	} mem_req_t;

	// answers every request once, rdata only meaningful for reads
	typedef struct packed {
		logic                       valid;
		logic [isa_pkg::word_w-1:0] rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic                       valid;
		logic [isa_pkg::word_w-1:0] value;
	} out_port_t;

	typedef enum logic [2:0] {
		fetch_req,
		fetch_wait,
		execute,
		mem_wait,
		halted
	} seq_state_e;

endpackage

//--- logic/isa_pkg.sv
package isa_pkg;

	// data path and address width
	localparam int word_w = 16;
	localparam int reg_count = 4;
	localparam int reg_addr_w = $clog2(reg_count);

	// instruction field widths
	localparam int op_w = 4;
	localparam int func_w = 6;
	localparam int imm_w = 8;
	localparam int target_w = 12;

	// JAL and JRL leave the return address in this register
	localparam logic [reg_addr_w-1:0] link_reg = 2'd2;

	typedef enum logic [op_w-1:0] {
		BNE   = 4'd0,
		BEQ   = 4'd1,
		BGZ   = 4'd2,
		BLZ   = 4'd3,
		ADI   = 4'd4,
		ORI   = 4'd5,
		LHI   = 4'd6,
		LWD   = 4'd7,
		SWD   = 4'd8,
		JMP   = 4'd9,
		JAL   = 4'd10,
		rtype = 4'd15
	} opcode_e;

	typedef enum logic [func_w-1:0] {
		ADD = 6'd0,
		SUB = 6'd1,
		AND = 6'd2,
		ORR = 6'd3,
		NOT = 6'd4,
		TCP = 6'd5,
		SHL = 6'd6,
		SHR = 6'd7,
		JPR = 6'd25,
		JRL = 6'd26,
		WWD = 6'd28,
		HLT = 6'd29
	} func_e;

	// first eight codes line up with the R-type function codes
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_not,
		alu_tcp,
		alu_shl,
		alu_shr,
		alu_pass_b
	} alu_op_e;

	typedef enum logic [1:0] {
		pc_seq,
		pc_branch,
		pc_target,
		pc_reg
	} pc_sel_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_pc
	} wb_src_e;

	typedef struct packed {
		alu_op_e               alu_op;
		logic                  alu_src_imm;
		logic                  reg_write;
		logic [reg_addr_w-1:0] write_addr;
		wb_src_e               wb_src;
		logic                  mem_read;
		logic                  mem_write;
		logic                  is_branch;
		logic [1:0]            branch_kind;
		pc_sel_e               pc_sel;
		logic                  is_wwd;
		logic                  is_hlt;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [word_w-1:0]     imm;
	} ctrl_t;

endpackage
